//--- hdl/uart_params.svh
////////////////////
// uart subsystem build parameters.
// clock, line rate, frame width and receive buffer size.
////////////////////
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// system clock in Hz.
`define UART_CLK_FREQ 10_000_000

// the line rate gives ten clocks per bit at the default clock.
`define UART_BAUD_RATE 1_000_000

`define UART_DATA_WIDTH 8

// the receive FIFO depth must be a power of two.
`define UART_FIFO_DEPTH 4

`endif

//--- hdl/uart_pkg.sv
////////////////////
// uart shared types.
// stream beat struct and the receiver and transmitter FSM states.
////////////////////
`default_nettype none
`include "uart_params.svh"

package uart_pkg;

    // this is the forward half of an AXI4-Stream byte link and tready travels apart.
    typedef struct packed {
        logic                        tvalid;
        logic [`UART_DATA_WIDTH-1:0] tdata;
    } axis_byte_t;

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,
        RX_START = 3'd1,
        RX_DATA  = 3'd2,
        RX_STOP  = 3'd3,
        RX_DONE  = 3'd4
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

`default_nettype wire

//--- hdl/uart_rx.sv
////////////////////
// uart receiver.
// samples 8N1 frames at mid-bit and presents each byte on a stream master.
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "uart_params.svh"

module uart_rx (
    input  wire                  clk_i,
    input  wire                  arstn_i,
    input  wire                  uart_rx_i,
    output uart_pkg::axis_byte_t m_axis_o,
    input  wire                  m_axis_tready_i,
    output logic                 frame_err_o,
    output logic                 overrun_o
);

    localparam int BIT_PERIOD = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int CNT_W      = $clog2(BIT_PERIOD);
    localparam int BIT_W      = $clog2(`UART_DATA_WIDTH);

    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BIT_PERIOD - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_PERIOD / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`UART_DATA_WIDTH - 1);

    uart_pkg::rx_state_e         state_q;
    logic                        rx_meta_q;
    logic                        rx_sync_q;
    logic [CNT_W-1:0]            baud_cnt_q;
    logic [BIT_W-1:0]            bit_cnt_q;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    logic                        out_valid_q;
    logic [`UART_DATA_WIDTH-1:0] out_data_q;
    logic                        baud_tick;
    logic                        half_tick;
    logic                        stop_sample;
    logic                        out_busy;
    logic                        load;

    // the line is asynchronous, so it passes two flops first.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    assign baud_tick   = (baud_cnt_q == BAUD_LAST);
    assign half_tick   = (state_q == uart_pkg::RX_START) && (baud_cnt_q == HALF_LAST);
    assign stop_sample = (state_q == uart_pkg::RX_STOP) && baud_tick;
    assign out_busy    = out_valid_q && !m_axis_tready_i;
    assign load        = stop_sample && rx_sync_q && !out_busy;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q    <= uart_pkg::RX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
            case (state_q)
                uart_pkg::RX_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    if (!rx_sync_q) begin
                        state_q <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    // a start bit that is gone by mid-bit was a glitch.
                    if (half_tick) begin
                        baud_cnt_q <= '0;
                        state_q    <= rx_sync_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (baud_tick) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_LAST) begin
                            state_q <= uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (baud_tick) begin
                        state_q <= uart_pkg::RX_DONE;
                    end
                end
                default: state_q <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, so bits enter at the top and move down.
    always_ff @(posedge clk_i) begin
        if ((state_q == uart_pkg::RX_DATA) && baud_tick) begin
            shift_q <= {rx_sync_q, shift_q[`UART_DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            out_valid_q <= 1'b0;
            frame_err_o <= 1'b0;
            overrun_o   <= 1'b0;
        end else begin
            frame_err_o <= stop_sample && !rx_sync_q;
            overrun_o   <= stop_sample && rx_sync_q && out_busy;
            if (load) begin
                out_valid_q <= 1'b1;
            end else if (m_axis_tready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_q <= shift_q;
        end
    end

    assign m_axis_o.tvalid = out_valid_q;
    assign m_axis_o.tdata  = out_data_q;

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
////////////////////
// uart transmitter.
// serializes stream bytes into 8N1 frames.
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "uart_params.svh"

module uart_tx (
    input  wire                  clk_i,
    input  wire                  arstn_i,
    input  wire uart_pkg::axis_byte_t s_axis_i,
    output logic                 s_axis_tready_o,
    output logic                 uart_tx_o
);

    localparam int BIT_PERIOD = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int CNT_W      = $clog2(BIT_PERIOD);
    localparam int BIT_W      = $clog2(`UART_DATA_WIDTH);

    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BIT_PERIOD - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`UART_DATA_WIDTH - 1);

    uart_pkg::tx_state_e         state_q;
    logic [CNT_W-1:0]            baud_cnt_q;
    logic [BIT_W-1:0]            bit_cnt_q;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    logic                        tx_q;
    logic                        baud_tick;
    logic                        accept;
    logic                        shift_en;

    assign s_axis_tready_o = (state_q == uart_pkg::TX_IDLE);
    assign accept          = s_axis_tready_o && s_axis_i.tvalid;
    assign baud_tick       = (baud_cnt_q == BAUD_LAST);
    assign shift_en        = baud_tick && ((state_q == uart_pkg::TX_START) ||
                                           (state_q == uart_pkg::TX_DATA));

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q    <= uart_pkg::TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_q       <= 1'b1;
        end else begin
            baud_cnt_q <= baud_tick ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    if (accept) begin
                        tx_q    <= 1'b0;
                        state_q <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (baud_tick) begin
                        tx_q    <= shift_q[0];
                        state_q <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (baud_tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_LAST) begin
                            tx_q    <= 1'b1;
                            state_q <= uart_pkg::TX_STOP;
                        end else begin
                            tx_q <= shift_q[0];
                        end
                    end
                end
                default: begin
                    if (baud_tick) begin
                        state_q <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // the byte is taken on accept and walks out lsb first.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q <= s_axis_i.tdata;
        end else if (shift_en) begin
            shift_q <= {1'b1, shift_q[`UART_DATA_WIDTH-1:1]};
        end
    end

    assign uart_tx_o = tx_q;

endmodule

`default_nettype wire

//--- hdl/axis_fifo.sv
////////////////////
// stream FIFO on a register array.
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "uart_params.svh"

module axis_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH,
    parameter int WIDTH = `UART_DATA_WIDTH
) (
    input  wire                  clk_i,
    input  wire                  arstn_i,
    input  wire uart_pkg::axis_byte_t s_axis_i,
    output logic                 s_axis_tready_o,
    output uart_pkg::axis_byte_t m_axis_o,
    input  wire                  m_axis_tready_i
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      count_q;
    logic             push;
    logic             pop;

    assign s_axis_tready_o = (count_q != (AW+1)'(DEPTH));
    assign m_axis_o.tvalid = (count_q != '0);
    assign m_axis_o.tdata  = mem_q[rd_ptr_q];

    assign push = s_axis_i.tvalid && s_axis_tready_o;
    assign pop  = m_axis_o.tvalid && m_axis_tready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_axis_i.tdata;
        end
    end

    // depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_axis_top.sv
////////////////////
// uart subsystem top.
// receiver into a FIFO, transmitter from the slave port.
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "uart_params.svh"

module uart_axis_top (
    input  wire                  clk_i,
    input  wire                  arstn_i,
    input  wire uart_pkg::axis_byte_t s_axis_i,
    output logic                 s_axis_tready_o,
    output logic                 uart_tx_o,
    input  wire                  uart_rx_i,
    output uart_pkg::axis_byte_t m_axis_o,
    input  wire                  m_axis_tready_i,
    output logic                 frame_err_o,
    output logic                 overrun_o
);

    uart_pkg::axis_byte_t rx_axis;
    logic                 rx_axis_tready;

    uart_rx i_uart_rx (
        .clk_i           (clk_i),
        .arstn_i         (arstn_i),
        .uart_rx_i       (uart_rx_i),
        .m_axis_o        (rx_axis),
        .m_axis_tready_i (rx_axis_tready),
        .frame_err_o     (frame_err_o),
        .overrun_o       (overrun_o)
    );

    // the receiver's output register adds one byte of slack on top of the FIFO.
    axis_fifo #(
        .DEPTH (`UART_FIFO_DEPTH),
        .WIDTH (`UART_DATA_WIDTH)
    ) i_axis_fifo (
        .clk_i           (clk_i),
        .arstn_i         (arstn_i),
        .s_axis_i        (rx_axis),
        .s_axis_tready_o (rx_axis_tready),
        .m_axis_o        (m_axis_o),
        .m_axis_tready_i (m_axis_tready_i)
    );

    uart_tx i_uart_tx (
        .clk_i           (clk_i),
        .arstn_i         (arstn_i),
        .s_axis_i        (s_axis_i),
        .s_axis_tready_o (s_axis_tready_o),
        .uart_tx_o       (uart_tx_o)
    );

endmodule

`default_nettype wire

//--- dv/uart_assert.sv
////////////////////
// protocol checks bound to the uart top.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module uart_assert (
    input wire                       clk_i,
    input wire                       arstn_i,
    input wire uart_pkg::axis_byte_t s_axis_i,
    input wire                       s_axis_tready_i,
    input wire uart_pkg::axis_byte_t m_axis_i,
    input wire                       m_axis_tready_i,
    input wire                       uart_tx_i,
    input wire                       frame_err_i,
    input wire                       overrun_i,
    input wire uart_pkg::tx_state_e  tx_state_i,
    input wire uart_pkg::rx_state_e  rx_state_i
);

    s_axis_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        s_axis_i.tvalid && !s_axis_tready_i |=> $stable(s_axis_i))
        else $error("s_axis beat changed while stalled");

    m_axis_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        m_axis_i.tvalid && !m_axis_tready_i |=> $stable(m_axis_i))
        else $error("m_axis beat changed while stalled");

    // the line idles high between frames.
    tx_idle_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (tx_state_i == uart_pkg::TX_IDLE) |-> uart_tx_i)
        else $error("uart_tx_o low while the transmitter is idle");

    frame_err_pulse: assert property (@(posedge clk_i) disable iff (!arstn_i)
        frame_err_i |=> !frame_err_i)
        else $error("frame_err_o high for more than one cycle");

    overrun_pulse: assert property (@(posedge clk_i) disable iff (!arstn_i)
        overrun_i |=> !overrun_i)
        else $error("overrun_o high for more than one cycle");

    // both flags come from the stop sample, so the receiver sits in DONE.
    flag_in_done: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (frame_err_i || overrun_i) |-> (rx_state_i == uart_pkg::RX_DONE))
        else $error("status pulse outside the DONE state");

endmodule

bind uart_axis_top uart_assert i_uart_assert (
    .clk_i           (clk_i),
    .arstn_i         (arstn_i),
    .s_axis_i        (s_axis_i),
    .s_axis_tready_i (s_axis_tready_o),
    .m_axis_i        (m_axis_o),
    .m_axis_tready_i (m_axis_tready_i),
    .uart_tx_i       (uart_tx_o),
    .frame_err_i     (frame_err_o),
    .overrun_i       (overrun_o),
    .tx_state_i      (i_uart_tx.state_q),
    .rx_state_i      (i_uart_rx.state_q)
);

`default_nettype wire

//--- dv/uart_tb.sv
////////////////////
// uart subsystem testbench.
// table of loopback and bit-banged frames with a byte scoreboard.
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "uart_params.svh"

module uart_tb;

    localparam int B         = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int DW        = `UART_DATA_WIDTH;
    localparam int HOLD_MAX  = `UART_FIFO_DEPTH + 1;
    localparam int NUM_TESTS = 15;
    localparam int TIMEOUT   = (NUM_TESTS * 12 + 40) * B;

    typedef enum logic [1:0] {MODE_LOOP, MODE_GOOD, MODE_BAD, MODE_GLITCH} mode_e;
    typedef enum logic [1:0] {RDY_ON, RDY_RAND, RDY_HOLD} rdy_e;

    typedef struct packed {
        logic [DW-1:0] data;
        mode_e         mode;
        rdy_e          rdy;
    } entry_t;

    // entries 4 to 10 stall the sink, so the last two of them overflow the path.
    localparam entry_t TESTS [NUM_TESTS] = '{
        '{8'hA5, MODE_LOOP, RDY_RAND},   '{8'h3C, MODE_LOOP, RDY_RAND},
        '{8'h00, MODE_LOOP, RDY_ON},     '{8'hFF, MODE_LOOP, RDY_RAND},
        '{8'h11, MODE_GOOD, RDY_HOLD},   '{8'h22, MODE_GOOD, RDY_HOLD},
        '{8'h44, MODE_GOOD, RDY_HOLD},   '{8'h88, MODE_GOOD, RDY_HOLD},
        '{8'h5A, MODE_GOOD, RDY_HOLD},   '{8'hE7, MODE_GOOD, RDY_HOLD},
        '{8'h7E, MODE_GOOD, RDY_HOLD},   '{8'h96, MODE_BAD, RDY_RAND},
        '{8'h00, MODE_GLITCH, RDY_ON},   '{8'hC3, MODE_GOOD, RDY_ON},
        '{8'h69, MODE_LOOP, RDY_RAND}
    };

    logic                 clk;
    logic                 arstn;
    uart_pkg::axis_byte_t s_axis;
    logic                 s_axis_tready;
    logic                 uart_tx;
    logic                 uart_rx;
    uart_pkg::axis_byte_t m_axis;
    logic                 m_axis_tready;
    logic                 frame_err;
    logic                 overrun;
    logic                 loop_sel;
    logic                 bang_line;
    rdy_e                 rdy_mode;
    integer               seed = 38;
    int                   cycles = 0;
    int                   err_cnt = 0;
    int                   fail_cnt = 0;
    int                   ferr_seen = 0;
    int                   ovr_seen = 0;
    int                   exp_ferr = 0;
    int                   exp_ovr = 0;
    logic [DW-1:0]        exp_q [$];

    assign uart_rx = loop_sel ? uart_tx : bang_line;

    uart_axis_top i_uart_axis_top (
        .clk_i           (clk),
        .arstn_i         (arstn),
        .s_axis_i        (s_axis),
        .s_axis_tready_o (s_axis_tready),
        .uart_tx_o       (uart_tx),
        .uart_rx_i       (uart_rx),
        .m_axis_o        (m_axis),
        .m_axis_tready_i (m_axis_tready),
        .frame_err_o     (frame_err),
        .overrun_o       (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare(input string what, input int got, input int expected);
        if (got !== expected) begin
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            err_cnt++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bang_frame(input logic [DW-1:0] data, input logic stop_bit);
        bang_line = 1'b0;
        wait_cycles(B);
        for (int i = 0; i < DW; i++) begin
            bang_line = data[i];
            wait_cycles(B);
        end
        bang_line = stop_bit;
        wait_cycles(B);
        bang_line = 1'b1;
        wait_cycles(2 * B);
    endtask

    task automatic run_entry(input entry_t e);
        rdy_mode = e.rdy;
        loop_sel = (e.mode == MODE_LOOP);
        case (e.mode)
            MODE_LOOP: begin
                exp_q.push_back(e.data);
                s_axis.tdata  = e.data;
                s_axis.tvalid = 1'b1;
                while (!s_axis_tready) begin
                    wait_cycles(1);
                end
                wait_cycles(1);
                s_axis.tvalid = 1'b0;
            end
            MODE_GOOD: begin
                // a stalled sink leaves room for the FIFO plus the receiver register.
                if (e.rdy == RDY_HOLD && exp_q.size() >= HOLD_MAX) begin
                    exp_ovr++;
                end else begin
                    exp_q.push_back(e.data);
                end
                bang_frame(e.data, 1'b1);
            end
            MODE_BAD: begin
                exp_ferr++;
                bang_frame(e.data, 1'b0);
            end
            default: begin
                bang_line = 1'b0;
                wait_cycles(B / 4);
                bang_line = 1'b1;
                wait_cycles(2 * B);
            end
        endcase
        if (e.rdy != RDY_HOLD) begin
            while (exp_q.size() != 0) begin
                wait_cycles(1);
            end
        end
        compare("framing error pulses", ferr_seen, exp_ferr);
        compare("overrun pulses", ovr_seen, exp_ovr);
    endtask

    task automatic report_test(input int idx, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", idx, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", idx, name, errs);
            fail_cnt++;
        end
    endtask

    always @(posedge clk) begin
        #1;
        case (rdy_mode)
            RDY_ON:   m_axis_tready = 1'b1;
            RDY_HOLD: m_axis_tready = 1'b0;
            default:  m_axis_tready = (($random(seed) % 4) != 0);
        endcase
    end

    // this samples mid-cycle, so a transfer seen here completes on the next rising edge.
    always @(negedge clk) begin
        if (arstn) begin
            if (frame_err) begin
                ferr_seen++;
            end
            if (overrun) begin
                ovr_seen++;
            end
            if (m_axis.tvalid && m_axis_tready) begin
                compare("byte expected on m_axis", (exp_q.size() != 0) ? 1 : 0, 1);
                if (exp_q.size() != 0) begin
                    compare("m_axis byte", int'(m_axis.tdata), int'(exp_q.pop_front()));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        entry_t e;
        int     errs_before;
        arstn         = 1'b0;
        s_axis        = '0;
        m_axis_tready = 1'b0;
        loop_sel      = 1'b0;
        bang_line     = 1'b1;
        rdy_mode      = RDY_ON;
        repeat (8) @(posedge clk);
        #1;
        arstn = 1'b1;

        errs_before = err_cnt;
        compare("uart_tx_o after reset", int'(uart_tx), 1);
        compare("s_axis_tready_o after reset", int'(s_axis_tready), 1);
        compare("m_axis_o tvalid after reset", int'(m_axis.tvalid), 0);
        compare("frame_err_o after reset", int'(frame_err), 0);
        compare("overrun_o after reset", int'(overrun), 0);
        report_test(0, "reset", err_cnt - errs_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            e = TESTS[i];
            errs_before = err_cnt;
            run_entry(e);
            report_test(i + 1, e.mode.name(), err_cnt - errs_before);
        end

        wait_cycles(2 * B);
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS + 1, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/axis_fifo.sv
hdl/uart_axis_top.sv
dv/uart_assert.sv
dv/uart_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= uart_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
